// ==== all.f ====
hw/mips_exc_pkg.sv
hw/retire_pkg.sv
hw/exc_resolve.sv
hw/cp0_commit.sv
hw/exc_top.sv
dv/exc_top_sva.sv
dv/tb_exc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the exception commit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exc_top -f all.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// ==== dv/tb_exc_top.sv ====
`timescale 1ns/1ps

module tb_exc_top;

    import mips_exc_pkg::*;
    import retire_pkg::*;

    localparam int          CREDITS        = 4;
    localparam int          TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] VECTOR         = DEFAULT_EXC_VECTOR;

    typedef struct packed {
        ret_kind_e   kind;
        logic [31:0] pc;
        logic        ds;
        logic        ri;
        logic        ovf;
        logic        aerr;
        logic [31:0] addr;
        cp0_sel_e    sel;
        logic [31:0] wdata;
        int          due;
    } item_t;

    logic        clk;
    logic        rst_n;
    logic        ret_valid;
    ret_kind_e   ret_kind;
    logic [31:0] ret_pc;
    logic        ret_in_ds;
    logic        ret_ri;
    logic        ret_ovf;
    logic        ret_addr_err;
    logic [31:0] ret_addr;
    cp0_sel_e    ret_cp0_sel;
    logic [31:0] ret_wdata;
    logic [5:0]  hw_int;
    cp0_sel_e    cp0_rd_sel;
    logic        credit_return;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] cp0_rd_data;

    int          seed = 32'ha0f2;
    int          errors;
    int          credits;
    int          neg_cnt;
    int          last_trap;
    int          cycle_cnt;
    item_t       pending[$];
    item_t       done_it;
    logic        want_redir;
    logic [31:0] want_pc;

    // reference copy of the cp0 state.
    logic        m_ie;
    logic        m_exl;
    logic [7:0]  m_im;
    logic        m_bd;
    logic [1:0]  m_sw_ip;
    exc_code_e   m_exc;
    logic [31:0] m_epc;
    logic [31:0] m_bad;

    exc_top #(.EXC_VECTOR(VECTOR)) UUT (.*);

    bind exc_top exc_top_sva u_sva (
        .clk            (clk),
        .rst_n          (rst_n),
        .ret_valid      (ret_valid),
        .credit_return  (credit_return),
        .redirect_valid (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, want, got);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR at t=%0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    // ====================
    // reference model
    // ====================

    function automatic logic sync_cause(input item_t it, output exc_code_e code,
                                        output logic [31:0] bad);
        code = INT;
        bad  = '0;
        if (it.pc[1:0] != 2'b00) begin
            code = ADEL;
            bad  = it.pc;
        end else if (it.ri) code = RI;
        else if (it.ovf) code = OV;
        else if (it.kind == SYSCALL) code = SYS;
        else if (it.kind == BREAK) code = BP;
        else if (it.aerr && (it.kind == LOAD || it.kind == STORE)) begin
            code = (it.kind == LOAD) ? ADEL : ADES;
            bad  = it.addr;
        end else return 1'b0;
        return 1'b1;
    endfunction

    function automatic logic [31:0] model_reg(input cp0_sel_e sel);
        logic [31:0] w;
        w = '0;
        case (sel)
            STATUS: begin
                w[STATUS_IE]           = m_ie;
                w[STATUS_EXL]          = m_exl;
                w[STATUS_IM_LO +: 8]   = m_im;
            end
            CAUSE: begin
                w[CAUSE_BD]            = m_bd;
                w[CAUSE_IP_LO +: 8]    = {hw_int, m_sw_ip};
                w[CAUSE_EXC_LO +: 5]   = m_exc;
            end
            EPC: w = m_epc;
            default: w = m_bad;
        endcase
        return w;
    endfunction

    task automatic apply_commit(input item_t it, output logic redir, output logic [31:0] rpc);
        logic        int_pend;
        logic        trap;
        exc_code_e   code;
        exc_code_e   scode;
        logic [31:0] bad;
        logic [31:0] sbad;
        int_pend = m_ie && !m_exl && (|({hw_int, m_sw_ip} & m_im));
        trap  = 1'b1;
        code  = INT;
        bad   = m_bad;
        redir = 1'b0;
        rpc   = '0;
        if (int_pend) code = INT;
        else if (sync_cause(it, scode, sbad)) begin
            code = scode;
            if (scode == ADEL || scode == ADES) bad = sbad;
        end else if (it.kind == ERET && m_epc[1:0] != 2'b00) begin
            code = ADEL;
            bad  = m_epc;
        end else trap = 1'b0;
        if (trap) begin
            if (!m_exl) begin
                m_epc = it.ds ? it.pc - 32'd4 : it.pc;
                m_bd  = it.ds;
            end
            m_exl = 1'b1;
            m_exc = code;
            m_bad = bad;
            redir = 1'b1;
            rpc   = VECTOR;
        end else if (it.kind == ERET) begin
            m_exl = 1'b0;
            redir = 1'b1;
            rpc   = m_epc;
        end else if (it.kind == MTC0) begin
            case (it.sel)
                STATUS: begin
                    m_ie  = it.wdata[STATUS_IE];
                    m_exl = it.wdata[STATUS_EXL];
                    m_im  = it.wdata[STATUS_IM_LO +: 8];
                end
                CAUSE: m_sw_ip = it.wdata[CAUSE_IP_LO +: 2];
                EPC: m_epc = it.wdata;
                default: ;
            endcase
        end
    endtask

    // retires items in order and checks credit timing and redirects.
    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (rst_n && credit_return) begin
            credits = credits + 1;
            if (pending.size() == 0) begin
                note_failure("credit_return with no item outstanding");
            end else begin
                done_it = pending.pop_front();
                if (done_it.due != neg_cnt) note_failure("credit returned at the wrong cycle");
                want_redir = 1'b0;
                want_pc    = '0;
                // items inside the trap shadow are dropped.
                if (neg_cnt - last_trap > 2) apply_commit(done_it, want_redir, want_pc);
                if (want_redir) last_trap = neg_cnt;
                if (redirect_valid !== want_redir) begin
                    report_mismatch("redirect_valid", want_redir, redirect_valid);
                end
                if (want_redir && redirect_pc !== want_pc) begin
                    report_mismatch("redirect_pc", want_pc, redirect_pc);
                end
            end
        end else if (rst_n) begin
            if (redirect_valid) note_failure("redirect_valid high without a credit");
            if (pending.size() != 0 && pending[0].due <= neg_cnt) begin
                note_failure("credit for an accepted item never came back");
                void'(pending.pop_front());
            end
        end
    end

    // ====================
    // stimulus helpers
    // ====================

    task automatic send_item(input ret_kind_e kind, input logic [31:0] pc, input logic ds,
                             input logic ri, input logic ovf, input logic aerr,
                             input logic [31:0] addr, input cp0_sel_e sel,
                             input logic [31:0] wdata);
        item_t it;
        @(posedge clk);
        if (credits == 0) begin
            ret_valid <= 1'b0;
            while (credits == 0) @(posedge clk);
        end
        it = '{kind, pc, ds, ri, ovf, aerr, addr, sel, wdata, neg_cnt + 3};
        ret_valid    <= 1'b1;
        ret_kind     <= kind;
        ret_pc       <= pc;
        ret_in_ds    <= ds;
        ret_ri       <= ri;
        ret_ovf      <= ovf;
        ret_addr_err <= aerr;
        ret_addr     <= addr;
        ret_cp0_sel  <= sel;
        ret_wdata    <= wdata;
        credits--;
        pending.push_back(it);
    endtask

    task automatic send_simple(input ret_kind_e kind, input logic [31:0] pc);
        send_item(kind, pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, STATUS, '0);
    endtask

    // stop sending and wait until every item has retired.
    task automatic settle();
        @(posedge clk);
        ret_valid <= 1'b0;
        while (pending.size() != 0) @(negedge clk);
    endtask

    task automatic write_cp0(input cp0_sel_e sel, input logic [31:0] wdata);
        send_item(MTC0, rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, '0, sel, wdata);
        settle();
    endtask

    task automatic recover();
        settle();
        write_cp0(EPC, rand_pc());
        send_simple(ERET, rand_pc());
        settle();
    endtask

    task automatic set_int(input logic [5:0] lines);
        @(posedge clk);
        hw_int <= lines;
    endtask

    task automatic read_check(input cp0_sel_e sel, output logic [31:0] val);
        logic [31:0] want;
        @(posedge clk);
        cp0_rd_sel <= sel;
        @(negedge clk);
        want = model_reg(sel);
        val  = cp0_rd_data;
        if (cp0_rd_data !== want) report_mismatch(sel.name(), want, cp0_rd_data);
    endtask

    task automatic check_all();
        logic [31:0] v;
        read_check(STATUS, v);
        read_check(CAUSE, v);
        read_check(EPC, v);
        read_check(BADVADDR, v);
    endtask

    // ====================
    // tests
    // ====================

    task automatic reset_and_credits();
        if (redirect_valid !== 1'b0) report_mismatch("redirect_valid", 0, redirect_valid);
        if (credit_return !== 1'b0) report_mismatch("credit_return", 0, credit_return);
        check_all();
        for (int i = 0; i < 12; i++) send_simple(ALU, rand_pc());
        settle();
        if (credits != CREDITS) note_failure("not all credits came back");
        check_all();
    endtask

    task automatic sync_priority();
        logic [31:0] pc;
        logic [31:0] v;
        ret_kind_e   kind;
        logic        ds;
        logic        ri;
        logic        ovf;
        logic        aerr;
        exc_code_e   want;
        for (int i = 0; i < 11; i++) begin
            pc   = rand_pc();
            kind = ALU;
            ds   = 1'b0;
            ri   = 1'b0;
            ovf  = 1'b0;
            aerr = 1'b0;
            want = INT;
            case (i)
                0: begin ri = 1'b1; want = RI; end
                1: begin ovf = 1'b1; want = OV; end
                2: begin kind = SYSCALL; want = SYS; end
                3: begin kind = BREAK; want = BP; end
                4: begin kind = LOAD; aerr = 1'b1; want = ADEL; end
                5: begin kind = STORE; aerr = 1'b1; want = ADES; end
                6: begin pc[1] = 1'b1; ri = 1'b1; want = ADEL; end
                7: begin ri = 1'b1; ovf = 1'b1; want = RI; end
                8: begin kind = SYSCALL; ovf = 1'b1; want = OV; end
                9: begin kind = STORE; aerr = 1'b1; ovf = 1'b1; ds = 1'b1; want = OV; end
                default: aerr = 1'b1;
            endcase
            send_item(kind, pc, ds, ri, ovf, aerr, rand_pc() | 32'h1, STATUS, '0);
            settle();
            check_all();
            read_check(CAUSE, v);
            if (i < 10 && v[CAUSE_EXC_LO +: 5] !== want) report_mismatch("exc_code", want, v[6:2]);
            if (i == 9) begin
                read_check(EPC, v);
                if (v !== pc - 32'd4) report_mismatch("epc", pc - 32'd4, v);
            end
            recover();
        end
    endtask

    task automatic interrupts();
        logic [31:0] pc;
        logic [31:0] v;
        write_cp0(STATUS, 32'h0000_0401);
        set_int(6'h01);
        pc = rand_pc();
        send_simple(ALU, pc);
        settle();
        read_check(CAUSE, v);
        if (v[CAUSE_EXC_LO +: 5] !== INT) report_mismatch("exc_code", INT, v[6:2]);
        read_check(EPC, v);
        if (v !== pc) report_mismatch("epc", pc, v);
        // the line stays masked while exl is set.
        send_simple(ALU, rand_pc());
        settle();
        set_int(6'h00);
        recover();
        write_cp0(STATUS, 32'h0000_0400);
        set_int(6'h01);
        send_simple(ALU, rand_pc());
        settle();
        write_cp0(STATUS, 32'h0000_0001);
        send_simple(ALU, rand_pc());
        settle();
        set_int(6'h00);
        write_cp0(STATUS, 32'h0000_0101);
        write_cp0(CAUSE, 32'h0000_0100);
        send_simple(ALU, rand_pc());
        settle();
        read_check(CAUSE, v);
        if (v[CAUSE_EXC_LO +: 5] !== INT) report_mismatch("exc_code", INT, v[6:2]);
        write_cp0(CAUSE, 32'h0);
        write_cp0(STATUS, 32'h0);
        recover();
        set_int(6'h2a);
        read_check(CAUSE, v);
        if (v[15:10] !== 6'h2a) report_mismatch("cause_ip_hw", 6'h2a, v[15:10]);
        set_int(6'h00);
        check_all();
    endtask

    task automatic eret_return();
        logic [31:0] bad_epc;
        logic [31:0] v;
        write_cp0(EPC, rand_pc());
        send_simple(ERET, rand_pc());
        settle();
        read_check(STATUS, v);
        if (v[STATUS_EXL] !== 1'b0) report_mismatch("status_exl", 0, v[STATUS_EXL]);
        bad_epc = rand_pc() | 32'h2;
        write_cp0(STATUS, 32'h0000_0002);
        write_cp0(EPC, bad_epc);
        send_simple(ERET, rand_pc());
        settle();
        read_check(CAUSE, v);
        if (v[CAUSE_EXC_LO +: 5] !== ADEL) report_mismatch("exc_code", ADEL, v[6:2]);
        read_check(BADVADDR, v);
        if (v !== bad_epc) report_mismatch("badvaddr", bad_epc, v);
        read_check(EPC, v);
        if (v !== bad_epc) report_mismatch("epc", bad_epc, v);
        recover();
    endtask

    task automatic nested_shadow();
        logic [31:0] first_pc;
        logic [31:0] late_epc;
        logic [31:0] v;
        first_pc = rand_pc();
        send_item(ALU, first_pc, 1'b0, 1'b0, 1'b1, 1'b0, '0, STATUS, '0);
        settle();
        send_item(ALU, rand_pc(), 1'b0, 1'b1, 1'b0, 1'b0, '0, STATUS, '0);
        settle();
        read_check(CAUSE, v);
        if (v[CAUSE_EXC_LO +: 5] !== RI) report_mismatch("exc_code", RI, v[6:2]);
        read_check(EPC, v);
        if (v !== first_pc) report_mismatch("epc", first_pc, v);
        recover();
        // trap, two wrong-path writes, then one that lands.
        late_epc = rand_pc();
        send_item(ALU, rand_pc(), 1'b0, 1'b1, 1'b0, 1'b0, '0, STATUS, '0);
        send_item(MTC0, rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, '0, STATUS, 32'h0000_ff01);
        send_item(MTC0, rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, '0, CAUSE, 32'h0000_0300);
        send_item(MTC0, rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, '0, EPC, late_epc);
        settle();
        read_check(EPC, v);
        if (v !== late_epc) report_mismatch("epc", late_epc, v);
        read_check(STATUS, v);
        if (v !== 32'h0000_0002) report_mismatch("status", 32'h0000_0002, v);
        read_check(CAUSE, v);
        if (v[CAUSE_IP_LO +: 2] !== 2'b00) report_mismatch("cause_sw_ip", 2'b00, v[9:8]);
        if (credits != CREDITS) note_failure("shadowed items did not return their credits");
        recover();
    endtask

    initial begin
        rst_n        = 1'b0;
        ret_valid    = 1'b0;
        ret_kind     = ALU;
        ret_pc       = '0;
        ret_in_ds    = 1'b0;
        ret_ri       = 1'b0;
        ret_ovf      = 1'b0;
        ret_addr_err = 1'b0;
        ret_addr     = '0;
        ret_cp0_sel  = STATUS;
        ret_wdata    = '0;
        hw_int       = '0;
        cp0_rd_sel   = STATUS;
        errors       = 0;
        credits      = CREDITS;
        neg_cnt      = 0;
        last_trap    = -10;
        m_ie         = 1'b0;
        m_exl        = 1'b0;
        m_im         = '0;
        m_bd         = 1'b0;
        m_sw_ip      = '0;
        m_exc        = INT;
        m_epc        = '0;
        m_bad        = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_and_credits();
        sync_priority();
        interrupts();
        eret_return();
        nested_shadow();
        settle();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/exc_top_sva.sv ====
`timescale 1ns/1ps

module exc_top_sva (
    input logic clk,
    input logic rst_n,
    input logic ret_valid,
    input logic credit_return,
    input logic redirect_valid
);

    localparam int CREDITS = 4;

    // items accepted whose credit has not come back yet.
    int inflight;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight <= 0;
        end else begin
            inflight <= inflight + int'(ret_valid) - int'(credit_return);
        end
    end

    // ====================
    // credit rules
    // ====================

    a_credit_not_ahead: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return |-> inflight > 0)
        else $error("credit returned with no item outstanding");

    a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid |-> inflight < CREDITS)
        else $error("item sent with zero credits held");

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !redirect_valid && !credit_return)
        else $error("outputs active in first cycle after reset");

    // a redirect always belongs to a retired item.
    a_redirect_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> credit_return)
        else $error("redirect without credit return");

endmodule

// ==== hw/exc_top.sv ====
`timescale 1ns/1ps

module exc_top #(
    parameter logic [31:0] EXC_VECTOR = mips_exc_pkg::DEFAULT_EXC_VECTOR
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ret_valid,
    input  retire_pkg::ret_kind_e  ret_kind,
    input  logic [31:0]            ret_pc,
    input  logic                   ret_in_ds,
    input  logic                   ret_ri,
    input  logic                   ret_ovf,
    input  logic                   ret_addr_err,
    input  logic [31:0]            ret_addr,
    input  mips_exc_pkg::cp0_sel_e ret_cp0_sel,
    input  logic [31:0]            ret_wdata,
    input  logic [5:0]             hw_int,
    input  mips_exc_pkg::cp0_sel_e cp0_rd_sel,
    output logic                   credit_return,
    output logic                   redirect_valid,
    output logic [31:0]            redirect_pc,
    output logic [31:0]            cp0_rd_data
);

    import mips_exc_pkg::*;
    import retire_pkg::*;

    // stage 1 to stage 2 link.
    logic        s1_valid;
    ret_kind_e   s1_kind;
    logic [31:0] s1_pc;
    logic        s1_in_ds;
    cp0_sel_e    s1_cp0_sel;
    logic [31:0] s1_wdata;
    logic        s1_exc;
    exc_code_e   s1_exc_code;
    logic [31:0] s1_badvaddr;

    exc_resolve u_exc_resolve (
        .clk          (clk),
        .rst_n        (rst_n),
        .ret_valid    (ret_valid),
        .ret_kind     (ret_kind),
        .ret_pc       (ret_pc),
        .ret_in_ds    (ret_in_ds),
        .ret_ri       (ret_ri),
        .ret_ovf      (ret_ovf),
        .ret_addr_err (ret_addr_err),
        .ret_addr     (ret_addr),
        .ret_cp0_sel  (ret_cp0_sel),
        .ret_wdata    (ret_wdata),
        .s1_valid     (s1_valid),
        .s1_kind      (s1_kind),
        .s1_pc        (s1_pc),
        .s1_in_ds     (s1_in_ds),
        .s1_cp0_sel   (s1_cp0_sel),
        .s1_wdata     (s1_wdata),
        .s1_exc       (s1_exc),
        .s1_exc_code  (s1_exc_code),
        .s1_badvaddr  (s1_badvaddr)
    );

    cp0_commit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_cp0_commit (
        .clk            (clk),
        .rst_n          (rst_n),
        .hw_int         (hw_int),
        .s1_valid       (s1_valid),
        .s1_kind        (s1_kind),
        .s1_pc          (s1_pc),
        .s1_in_ds       (s1_in_ds),
        .s1_cp0_sel     (s1_cp0_sel),
        .s1_wdata       (s1_wdata),
        .s1_exc         (s1_exc),
        .s1_exc_code    (s1_exc_code),
        .s1_badvaddr    (s1_badvaddr),
        .cp0_rd_sel     (cp0_rd_sel),
        .credit_return  (credit_return),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .cp0_rd_data    (cp0_rd_data)
    );

endmodule

// ==== hw/cp0_commit.sv ====
`timescale 1ns/1ps

module cp0_commit #(
    parameter logic [31:0] EXC_VECTOR = mips_exc_pkg::DEFAULT_EXC_VECTOR
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [5:0]              hw_int,
    input  logic                    s1_valid,
    input  retire_pkg::ret_kind_e   s1_kind,
    input  logic [31:0]             s1_pc,
    input  logic                    s1_in_ds,
    input  mips_exc_pkg::cp0_sel_e  s1_cp0_sel,
    input  logic [31:0]             s1_wdata,
    input  logic                    s1_exc,
    input  mips_exc_pkg::exc_code_e s1_exc_code,
    input  logic [31:0]             s1_badvaddr,
    input  mips_exc_pkg::cp0_sel_e  cp0_rd_sel,
    output logic                    credit_return,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc,
    output logic [31:0]             cp0_rd_data
);

    import mips_exc_pkg::*;
    import retire_pkg::*;

    // architectural state.
    logic                status_ie;
    logic                status_exl;
    logic [IM_WIDTH-1:0] status_im;
    logic                cause_bd;
    logic [1:0]          cause_sw_ip;
    exc_code_e           cause_exc;
    logic [31:0]         epc_q;
    logic [31:0]         badvaddr_q;

    // cycles left in the trap shadow.
    logic [1:0]          shadow_cnt;

    logic [IM_WIDTH-1:0] ip;
    logic                live;
    logic                int_pend;
    logic                take_int;
    logic                take_sync;
    logic                eret_bad;
    logic                take_exc;
    logic                clean_eret;
    logic                clean_mtc0;
    logic                write_bad;
    exc_code_e           code_c;
    logic [31:0]         bad_c;
    logic [31:0]         status_word;
    logic [31:0]         cause_word;

    // ====================
    // outcome decode
    // ====================

    assign ip       = {hw_int, cause_sw_ip};
    assign live     = s1_valid && (shadow_cnt == 2'd0);
    // EXL masks interrupts only.
    assign int_pend = status_ie && !status_exl && (|(ip & status_im));

    assign take_int   = live && int_pend;
    assign take_sync  = live && !int_pend && s1_exc;
    assign eret_bad   = live && !int_pend && !s1_exc && (s1_kind == ERET)
                        && (epc_q[1:0] != 2'b00);
    assign clean_eret = live && !int_pend && !s1_exc && (s1_kind == ERET)
                        && (epc_q[1:0] == 2'b00);
    assign clean_mtc0 = live && !int_pend && !s1_exc && (s1_kind == MTC0);
    assign take_exc   = take_int || take_sync || eret_bad;

    always_comb begin
        code_c    = INT;
        bad_c     = s1_badvaddr;
        write_bad = 1'b0;
        if (take_sync) begin
            code_c    = s1_exc_code;
            write_bad = (s1_exc_code == ADEL) || (s1_exc_code == ADES);
        end else if (eret_bad) begin
            // eret to a misaligned epc faults as a fetch.
            code_c    = ADEL;
            bad_c     = epc_q;
            write_bad = 1'b1;
        end
    end

    // ====================
    // cp0 state
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_ie   <= 1'b0;
            status_exl  <= 1'b0;
            status_im   <= '0;
            cause_bd    <= 1'b0;
            cause_sw_ip <= 2'b00;
            cause_exc   <= INT;
            epc_q       <= '0;
            badvaddr_q  <= '0;
        end else if (take_exc) begin
            // nested fault keeps the original epc and bd.
            if (!status_exl) begin
                epc_q    <= s1_in_ds ? s1_pc - 32'd4 : s1_pc;
                cause_bd <= s1_in_ds;
            end
            status_exl <= 1'b1;
            cause_exc  <= code_c;
            if (write_bad) begin
                badvaddr_q <= bad_c;
            end
        end else if (clean_eret) begin
            status_exl <= 1'b0;
        end else if (clean_mtc0) begin
            case (s1_cp0_sel)
                STATUS: begin
                    status_ie  <= s1_wdata[STATUS_IE];
                    status_exl <= s1_wdata[STATUS_EXL];
                    status_im  <= s1_wdata[STATUS_IM_LO +: IM_WIDTH];
                end
                CAUSE: cause_sw_ip <= s1_wdata[CAUSE_IP_LO +: 2];
                EPC: epc_q <= s1_wdata;
                // read only.
                BADVADDR: ;
                default: ;
            endcase
        end
    end

    // two wrong-path items follow every trap or eret.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_cnt <= 2'd0;
        end else if (take_exc || clean_eret) begin
            shadow_cnt <= 2'd2;
        end else if (shadow_cnt != 2'd0) begin
            shadow_cnt <= shadow_cnt - 2'd1;
        end
    end

    // ====================
    // credits and redirect
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_return  <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            // discarded items still hand back their credit.
            credit_return  <= s1_valid;
            redirect_valid <= take_exc || clean_eret;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= take_exc ? EXC_VECTOR : epc_q;
    end

    // read port.
    always_comb begin
        status_word = '0;
        status_word[STATUS_IE] = status_ie;
        status_word[STATUS_EXL] = status_exl;
        status_word[STATUS_IM_LO +: IM_WIDTH] = status_im;
        cause_word = '0;
        cause_word[CAUSE_BD] = cause_bd;
        cause_word[CAUSE_IP_LO +: IM_WIDTH] = ip;
        cause_word[CAUSE_EXC_LO +: 5] = cause_exc;
    end

    always_comb begin
        case (cp0_rd_sel)
            STATUS:   cp0_rd_data = status_word;
            CAUSE:    cp0_rd_data = cause_word;
            EPC:      cp0_rd_data = epc_q;
            BADVADDR: cp0_rd_data = badvaddr_q;
            default:  cp0_rd_data = '0;
        endcase
    end

endmodule

// ==== hw/exc_resolve.sv ====
`timescale 1ns/1ps

module exc_resolve (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ret_valid,
    input  retire_pkg::ret_kind_e   ret_kind,
    input  logic [31:0]             ret_pc,
    input  logic                    ret_in_ds,
    input  logic                    ret_ri,
    input  logic                    ret_ovf,
    input  logic                    ret_addr_err,
    input  logic [31:0]             ret_addr,
    input  mips_exc_pkg::cp0_sel_e  ret_cp0_sel,
    input  logic [31:0]             ret_wdata,
    output logic                    s1_valid,
    output retire_pkg::ret_kind_e   s1_kind,
    output logic [31:0]             s1_pc,
    output logic                    s1_in_ds,
    output mips_exc_pkg::cp0_sel_e  s1_cp0_sel,
    output logic [31:0]             s1_wdata,
    output logic                    s1_exc,
    output mips_exc_pkg::exc_code_e s1_exc_code,
    output logic [31:0]             s1_badvaddr
);

    import mips_exc_pkg::*;
    import retire_pkg::*;

    logic        exc_c;
    exc_code_e   code_c;
    logic [31:0] bad_c;

    // ====================
    // cause encoder
    // ====================

    // fixed priority, fetch side faults first.
    always_comb begin
        exc_c  = 1'b0;
        code_c = INT;
        bad_c  = '0;
        if (ret_pc[1:0] != 2'b00) begin
            exc_c  = 1'b1;
            code_c = ADEL;
            bad_c  = ret_pc;
        end else if (ret_ri) begin
            exc_c  = 1'b1;
            code_c = RI;
        end else if (ret_ovf) begin
            exc_c  = 1'b1;
            code_c = OV;
        end else if (ret_kind == SYSCALL) begin
            exc_c  = 1'b1;
            code_c = SYS;
        end else if (ret_kind == BREAK) begin
            exc_c  = 1'b1;
            code_c = BP;
        end else if (ret_addr_err && ret_kind == LOAD) begin
            exc_c  = 1'b1;
            code_c = ADEL;
            bad_c  = ret_addr;
        end else if (ret_addr_err && ret_kind == STORE) begin
            exc_c  = 1'b1;
            code_c = ADES;
            bad_c  = ret_addr;
        end
    end

    // ====================
    // stage register
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= ret_valid;
        end
    end

    // payload, qualified by s1_valid downstream.
    always_ff @(posedge clk) begin
        s1_kind     <= ret_kind;
        s1_pc       <= ret_pc;
        s1_in_ds    <= ret_in_ds;
        s1_cp0_sel  <= ret_cp0_sel;
        s1_wdata    <= ret_wdata;
        s1_exc      <= exc_c;
        s1_exc_code <= code_c;
        s1_badvaddr <= bad_c;
    end

endmodule

// ==== hw/retire_pkg.sv ====
package retire_pkg;

    // ====================
    // retire stream
    // ====================

    // what the retiring instruction is, as seen by the commit path.
    typedef enum logic [2:0] {
        // plain arithmetic or logic op.
        ALU     = 3'd0,
        // memory read, may carry a data address error.
        LOAD    = 3'd1,
        // memory write, may carry a data address error.
        STORE   = 3'd2,
        // syscall instruction.
        SYSCALL = 3'd3,
        // break instruction.
        BREAK   = 3'd4,
        // return from exception.
        ERET    = 3'd5,
        // write to a cp0 register, data in the wdata field.
        MTC0    = 3'd6
    } ret_kind_e;

    // item kinds with a data access, so the address error flag applies.
    // all other kinds ignore it.

endpackage

// ==== hw/mips_exc_pkg.sv ====
package mips_exc_pkg;

    // ====================
    // exception codes
    // ====================

    // values as written to the ExcCode field of Cause.
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_e;

    // ====================
    // cp0 register map
    // ====================

    // selector shared by mtc0 and the read port.
    typedef enum logic [1:0] {
        STATUS   = 2'd0,
        CAUSE    = 2'd1,
        EPC      = 2'd2,
        BADVADDR = 2'd3
    } cp0_sel_e;

    // status fields.
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    // width of IM in Status and of IP in Cause.
    localparam int IM_WIDTH     = 8;

    // cause fields.
    localparam int CAUSE_BD     = 31;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_EXC_LO = 2;

    // general exception vector, boot space.
    localparam logic [31:0] DEFAULT_EXC_VECTOR = 32'hBFC0_0380;

endpackage
